// File: include/cd_dma_consts.svh
// Register window, register offsets and DMA microcodes
// Access wait counts, upload zone and area codes
`ifndef CD_DMA_CONSTS_SVH
`define CD_DMA_CONSTS_SVH

// ====================
// Address decode
`define CD_REG_WINDOW      15'h7F80   // Word address bits [22:8], byte FF0000-FF01FF
`define CD_UPLOAD_ZONE     4'hE       // Top nibble of the byte address

// Offsets are {page, byte offset in page}, always word aligned
`define REG_DMA_START      9'h060     // FF0061, low byte lane only
`define REG_DMA_ADDR_A_HI  9'h064     // FF0064
`define REG_DMA_ADDR_A_LO  9'h066     // FF0066
`define REG_DMA_ADDR_B_HI  9'h068     // FF0068
`define REG_DMA_ADDR_B_LO  9'h06A     // FF006A
`define REG_DMA_VALUE      9'h06C     // FF006C, high half of fill value
`define REG_DMA_COUNT_HI   9'h070     // FF0070
`define REG_DMA_COUNT_LO   9'h072     // FF0072
`define REG_DMA_UCODE0     9'h07E     // FF007E
`define REG_TR_AREA        9'h104     // FF0105
`define REG_MAP_SPR        9'h120     // FF0121
`define REG_MAP_PCM        9'h122     // FF0123
`define REG_MAP_Z80        9'h126     // FF0127
`define REG_MAP_FIX        9'h128     // FF0129
`define REG_UNMAP_SPR      9'h140     // FF0141
`define REG_UNMAP_PCM      9'h142     // FF0143
`define REG_UNMAP_Z80      9'h146     // FF0147
`define REG_UNMAP_FIX      9'h148     // FF0149

// ====================
// Microcode word 0 and timing
`define UCODE_WORD_COPY    16'hFE6D
`define UCODE_WORD_FILL    16'hFFCD
`define DMA_WAIT_READ      8'd20      // Minimum cycles per read
`define DMA_WAIT_WRITE     8'd20      // Minimum cycles per write

`define AREA_SPR           3'd0
`define AREA_PCM           3'd1
`define AREA_Z80           3'd4
`define AREA_FIX           3'd5

`endif

// File: logic/cd_dma_pkg.sv
// Shared types of the CD DMA block
// Vector typedefs, mode and state enums, bus and config structs
package cd_dma_pkg;

	typedef logic [23:0] addr24_t;    // Byte address
	typedef logic [22:0] hw_addr_t;   // Host word address, A23..A1
	typedef logic [18:0] tr_addr_t;   // Upload word address, A19..A1
	typedef logic [15:0] word_t;
	typedef logic [23:0] count_t;     // Word count
	typedef logic [2:0]  area_t;
	typedef logic [8:0]  reg_off_t;   // {page, byte offset}

	typedef enum logic
	{
		DMA_COPY_WORD,
		DMA_FILL_WORD
	} dma_mode_e;

	typedef enum logic [2:0]
	{
		IDLE,
		REQ,          // Assert bus request
		WAIT_GRANT,
		WAIT_IDLE,    // Wait for last host cycle to end
		LOOP,
		READ,
		WRITE,
		WRITE_DONE
	} dma_state_e;

	// Host pins as seen by the block
	typedef struct packed
	{
		hw_addr_t addr;
		word_t    data;
		logic     rw;
		logic     nas;
		logic     nlds;
		logic     nuds;
		logic     ndtack;
	} host_bus_t;

	typedef struct packed
	{
		logic     valid;   // One cycle
		reg_off_t offset;
		logic [1:0] lanes; // {nuds, nlds}
		word_t    data;
	} reg_write_t;

	typedef struct packed
	{
		dma_mode_e mode;
		addr24_t   addr_a;
		addr24_t   addr_b;
		word_t     value;
		count_t    count;
	} dma_cfg_t;

	typedef struct packed
	{
		logic spr;
		logic pcm;
		logic z80;
		logic fix;
	} map_flags_t;

endpackage

// File: logic/host_bus_decode.sv
// Host bus front end
// Data strobe edge detect, register write pulse, upload write capture
`include "cd_dma_consts.svh"

module host_bus_decode
	import cd_dma_pkg::*;
(
	input  logic       clk_sys,
	input  logic       nRESET,
	input  logic       cpu_clk_en,
	input  logic       sys_is_cd,
	input  host_bus_t  bus,
	output reg_write_t reg_wr,
	output word_t      tr_wr_data,
	output tr_addr_t   tr_wr_addr
);

	logic     nlds_prev;
	logic     nuds_prev;
	logic     strobe_fall;
	logic     in_window;
	logic     in_zone;
	logic     wr_valid;
	reg_off_t wr_offset;
	logic [1:0] wr_lanes;
	word_t    wr_data;

	// Either byte lane going active starts an access
	assign strobe_fall = sys_is_cd & ((nlds_prev & ~bus.nlds) | (nuds_prev & ~bus.nuds));
	assign in_window   = (bus.addr[22:8] == `CD_REG_WINDOW);
	assign in_zone     = (bus.addr[22:19] == `CD_UPLOAD_ZONE);

	// ====================
	// Edge history and write pulse
	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			nlds_prev <= 1'b1;
			nuds_prev <= 1'b1;
			wr_valid  <= 1'b0;
		end
		else
		begin
			wr_valid <= 1'b0;   // Pulse only
			if (cpu_clk_en)
			begin
				nlds_prev <= bus.nlds;
				nuds_prev <= bus.nuds;
				if (strobe_fall & ~bus.rw & in_window)
					wr_valid <= 1'b1;
			end
		end
	end

	// Payload, captured alongside the pulse
	always_ff @(posedge clk_sys)
	begin
		if (cpu_clk_en & strobe_fall & ~bus.rw)
		begin
			wr_offset <= {bus.addr[7:0], 1'b0};   // Page bit is A8
			wr_lanes  <= {bus.nuds, bus.nlds};
			wr_data   <= bus.data;
			if (in_zone)
			begin
				// Host upload write, kept for the memory side
				tr_wr_data <= bus.data;
				tr_wr_addr <= bus.addr[18:0];
			end
		end
	end

	assign reg_wr = '{valid: wr_valid, offset: wr_offset, lanes: wr_lanes, data: wr_data};

endmodule

// File: logic/cd_ctrl_regs.sv
// DMA setup registers and microcode check
// Upload area select, map flags, start pulse
`include "cd_dma_consts.svh"

module cd_ctrl_regs
	import cd_dma_pkg::*;
(
	input  logic       clk_sys,
	input  logic       nRESET,
	input  reg_write_t reg_wr,
	output dma_cfg_t   cfg,
	output logic       dma_start,
	output area_t      tr_area,
	output map_flags_t map
);

	addr24_t   addr_a;
	addr24_t   addr_b;
	word_t     value;
	count_t    count;
	word_t     ucode0;
	dma_mode_e mode;
	logic      start_wr;
	logic      ucode_copy;
	logic      ucode_fill;

	// Start bit is D6 of the low byte at FF0061
	assign start_wr   = reg_wr.valid & (reg_wr.offset == `REG_DMA_START) &
		(reg_wr.lanes == 2'b10) & reg_wr.data[6];
	assign ucode_copy = (ucode0 == `UCODE_WORD_COPY);
	assign ucode_fill = (ucode0 == `UCODE_WORD_FILL);

	// ====================
	// Setup registers
	always_ff @(posedge clk_sys)
	begin
		if (reg_wr.valid)
		begin
			casez ({reg_wr.offset, reg_wr.lanes})
				{`REG_DMA_ADDR_A_HI, 2'b00}: addr_a[23:16] <= reg_wr.data[7:0];
				{`REG_DMA_ADDR_A_LO, 2'b00}: addr_a[15:0]  <= reg_wr.data;
				{`REG_DMA_ADDR_B_HI, 2'b00}: addr_b[23:16] <= reg_wr.data[7:0];
				{`REG_DMA_ADDR_B_LO, 2'b00}: addr_b[15:0]  <= reg_wr.data;
				{`REG_DMA_VALUE,     2'b00}: value         <= reg_wr.data;
				{`REG_DMA_COUNT_HI,  2'b00}: count[23:16]  <= reg_wr.data[7:0];   // Top byte only
				{`REG_DMA_COUNT_LO,  2'b00}: count[15:0]   <= reg_wr.data;
				{`REG_DMA_UCODE0,    2'b00}: ucode0        <= reg_wr.data;
				default: ;
			endcase
		end
		// Mode follows the microcode seen at start time
		if (start_wr & ucode_copy)
			mode <= DMA_COPY_WORD;
		else if (start_wr & ucode_fill)
			mode <= DMA_FILL_WORD;
	end

	// ====================
	// Area, map flags, start
	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			tr_area   <= `AREA_SPR;
			map       <= '0;
			dma_start <= 1'b0;
		end
		else
		begin
			dma_start <= start_wr & (ucode_copy | ucode_fill);   // Unknown code ignored
			if (reg_wr.valid)
			begin
				casez ({reg_wr.offset, reg_wr.lanes})
					{`REG_TR_AREA,   2'b?0}: tr_area <= reg_wr.data[2:0];
					{`REG_MAP_SPR,   2'b?0}: map.spr <= 1'b1;
					{`REG_MAP_PCM,   2'b?0}: map.pcm <= 1'b1;
					{`REG_MAP_Z80,   2'b?0}: map.z80 <= 1'b1;
					{`REG_MAP_FIX,   2'b?0}: map.fix <= 1'b1;
					{`REG_UNMAP_SPR, 2'b?0}: map.spr <= 1'b0;
					{`REG_UNMAP_PCM, 2'b?0}: map.pcm <= 1'b0;
					{`REG_UNMAP_Z80, 2'b?0}: map.z80 <= 1'b0;
					{`REG_UNMAP_FIX, 2'b?0}: map.fix <= 1'b0;
					default: ;
				endcase
			end
		end
	end

	assign cfg = '{mode: mode, addr_a: addr_a, addr_b: addr_b, value: value, count: count};

endmodule

// File: logic/dma_sequencer.sv
// DMA engine
// Host bus request and grant sequence
// Word copy and word fill FSM with minimum wait timer
`include "cd_dma_consts.svh"

module dma_sequencer
	import cd_dma_pkg::*;
(
	input  logic     clk_sys,
	input  logic     nRESET,
	input  dma_cfg_t cfg,
	input  logic     dma_start,
	input  logic     nbg,
	input  logic     nas,
	input  logic     ndtack,
	input  logic     sdram_busy,
	input  word_t    dma_data_in,
	output logic     nbr,
	output logic     nbgack,
	output logic     dma_running,
	output logic     dma_rd,
	output logic     dma_wr,
	output addr24_t  dma_addr_in,
	output addr24_t  dma_addr_out,
	output word_t    dma_data_out
);

	dma_state_e state;
	dma_mode_e  mode_q;
	logic [7:0] wait_cnt;
	count_t     count_run;
	logic       step;

	// Advance only once the minimum wait is over and memory is free
	assign step = ~sdram_busy & (wait_cnt == 8'd0);

	// ====================
	// Control FSM
	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			state       <= IDLE;
			nbr         <= 1'b1;
			nbgack      <= 1'b1;
			dma_running <= 1'b0;
			dma_rd      <= 1'b0;
			dma_wr      <= 1'b0;
			wait_cnt    <= 8'd0;
		end
		else
		begin
			if (wait_cnt != 8'd0)
				wait_cnt <= wait_cnt - 1'b1;   // Ticks even when memory busy

			if (state == IDLE)
			begin
				if (dma_start)
				begin
					state       <= REQ;
					dma_running <= 1'b1;
				end
			end
			else if (step)
			begin
				case (state)
					REQ:
					begin
						nbr   <= 1'b0;
						state <= WAIT_GRANT;
					end
					WAIT_GRANT:
						if (!nbg)
							state <= WAIT_IDLE;
					WAIT_IDLE:
						if (nas & ndtack)   // Host cycle finished
						begin
							nbr    <= 1'b1;
							nbgack <= 1'b0;
							state  <= LOOP;
						end
					LOOP:
						if (count_run == '0)
						begin
							nbgack      <= 1'b1;   // Hand the bus back
							dma_running <= 1'b0;
							state       <= IDLE;
						end
						else if (mode_q == DMA_COPY_WORD)
						begin
							dma_rd   <= 1'b1;
							wait_cnt <= `DMA_WAIT_READ;
							state    <= READ;
						end
						else
						begin
							dma_wr   <= 1'b1;
							wait_cnt <= `DMA_WAIT_WRITE;
							state    <= WRITE;
						end
					READ:
					begin
						dma_rd   <= 1'b0;
						dma_wr   <= 1'b1;
						wait_cnt <= `DMA_WAIT_WRITE;
						state    <= WRITE;
					end
					WRITE:
					begin
						dma_wr <= 1'b0;
						state  <= WRITE_DONE;
					end
					WRITE_DONE:
						state <= LOOP;   // Count and addresses settled
					default:
						state <= IDLE;
				endcase
			end
		end
	end

	// ====================
	// Addresses, data and word count
	always_ff @(posedge clk_sys)
	begin
		if ((state == IDLE) & dma_start)
		begin
			mode_q       <= cfg.mode;
			count_run    <= cfg.count;
			dma_addr_in  <= cfg.addr_a;
			dma_data_out <= cfg.value;   // Fill value, replaced by reads in copy
			if (cfg.mode == DMA_FILL_WORD)
				dma_addr_out <= cfg.addr_a;
			else
				dma_addr_out <= cfg.addr_b;
		end
		else if (step)
		begin
			case (state)
				READ:
					dma_data_out <= dma_data_in;   // Read data at end of wait
				WRITE:
				begin
					dma_addr_out <= dma_addr_out + 24'd2;
					if (mode_q == DMA_COPY_WORD)
						dma_addr_in <= dma_addr_in + 24'd2;
					count_run <= count_run - 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

// File: logic/upload_router.sv
// Upload zone router
// E-zone select from DMA or host, per-area read and write strobes
`include "cd_dma_consts.svh"

module upload_router
	import cd_dma_pkg::*;
(
	input  host_bus_t  bus,
	input  logic       dma_running,
	input  logic       dma_rd,
	input  logic       dma_wr,
	input  addr24_t    dma_addr_out,
	input  area_t      tr_area,
	input  map_flags_t map,
	output logic       tr_wr_spr,
	output logic       tr_wr_pcm,
	output logic       tr_wr_z80,
	output logic       tr_wr_fix,
	output logic       tr_rd_spr,
	output logic       tr_rd_z80,
	output logic       tr_rd_fix
);

	logic tr_zone;
	logic host_strobe;
	logic zone_rd;
	logic zone_wr;
	logic sel_spr;
	logic sel_pcm;
	logic sel_z80;
	logic sel_fix;

	// DMA owns the address while running
	assign tr_zone = dma_running ? (dma_addr_out[23:20] == `CD_UPLOAD_ZONE)
		: (bus.addr[22:19] == `CD_UPLOAD_ZONE);

	assign host_strobe = ~(bus.nlds & bus.nuds);   // Any lane active
	assign zone_rd = tr_zone & (dma_running ? dma_rd : (bus.rw & host_strobe));
	assign zone_wr = tr_zone & (dma_running ? dma_wr : (~bus.rw & host_strobe));

	// Area selected and mapped in
	assign sel_spr = (tr_area == `AREA_SPR) & map.spr;
	assign sel_pcm = (tr_area == `AREA_PCM) & map.pcm;
	assign sel_z80 = (tr_area == `AREA_Z80) & map.z80;
	assign sel_fix = (tr_area == `AREA_FIX) & map.fix;

	assign tr_wr_spr = zone_wr & sel_spr;
	assign tr_wr_pcm = zone_wr & sel_pcm;
	assign tr_wr_z80 = zone_wr & sel_z80;
	assign tr_wr_fix = zone_wr & sel_fix;

	assign tr_rd_spr = zone_rd & sel_spr;   // No PCM readback
	assign tr_rd_z80 = zone_rd & sel_z80;
	assign tr_rd_fix = zone_rd & sel_fix;

endmodule

// File: logic/cd_dma_sys.sv
// CD DMA block top level
// Host decode, setup registers, DMA engine, upload router
module cd_dma_sys
	import cd_dma_pkg::*;
(
	input  logic     clk_sys,
	input  logic     nRESET,
	input  logic     cpu_clk_en,
	input  logic     sys_is_cd,
	input  hw_addr_t m68k_addr,
	input  word_t    m68k_data,
	input  logic     m68k_rw,
	input  logic     nas,
	input  logic     nlds,
	input  logic     nuds,
	input  logic     ndtack,
	input  logic     nbg,
	input  logic     sdram_busy,
	input  word_t    dma_data_in,
	output logic     nbr,
	output logic     nbgack,
	output logic     dma_running,
	output logic     dma_rd,
	output logic     dma_wr,
	output addr24_t  dma_addr_in,
	output addr24_t  dma_addr_out,
	output word_t    dma_data_out,
	output logic     tr_wr_spr,
	output logic     tr_wr_pcm,
	output logic     tr_wr_z80,
	output logic     tr_wr_fix,
	output logic     tr_rd_spr,
	output logic     tr_rd_z80,
	output logic     tr_rd_fix,
	output word_t    tr_wr_data,
	output tr_addr_t tr_wr_addr
);

	host_bus_t  host_bus;
	reg_write_t reg_wr;
	dma_cfg_t   cfg;
	logic       dma_start;
	area_t      tr_area;
	map_flags_t map;

	assign host_bus = '{addr: m68k_addr, data: m68k_data, rw: m68k_rw, nas: nas,
		nlds: nlds, nuds: nuds, ndtack: ndtack};

	host_bus_decode i_decode (
		.clk_sys, .nRESET, .cpu_clk_en, .sys_is_cd,
		.bus(host_bus), .reg_wr, .tr_wr_data, .tr_wr_addr
	);

	cd_ctrl_regs i_regs (
		.clk_sys, .nRESET, .reg_wr, .cfg, .dma_start, .tr_area, .map
	);

	dma_sequencer i_seq (
		.clk_sys, .nRESET, .cfg, .dma_start, .nbg, .nas, .ndtack, .sdram_busy,
		.dma_data_in, .nbr, .nbgack, .dma_running, .dma_rd, .dma_wr,
		.dma_addr_in, .dma_addr_out, .dma_data_out
	);

	upload_router i_router (
		.bus(host_bus), .dma_running, .dma_rd, .dma_wr, .dma_addr_out, .tr_area, .map,
		.tr_wr_spr, .tr_wr_pcm, .tr_wr_z80, .tr_wr_fix,
		.tr_rd_spr, .tr_rd_z80, .tr_rd_fix
	);

endmodule

// File: dv/tb_cd_dma_sys.sv
// Testbench for the CD DMA block
// Clock, host write task, memory and bus arbiter models, checking assertions
`include "cd_dma_consts.svh"

module tb_cd_dma_sys
	import cd_dma_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	logic clk_sys = 1'b0;
	logic nRESET, cpu_clk_en, sys_is_cd, m68k_rw, nas, nlds, nuds, ndtack, nbg, sdram_busy;
	hw_addr_t m68k_addr;
	word_t m68k_data, dma_data_in, dma_data_out, tr_wr_data;
	logic nbr, nbgack, dma_running, dma_rd, dma_wr;
	logic tr_wr_spr, tr_wr_pcm, tr_wr_z80, tr_wr_fix, tr_rd_spr, tr_rd_z80, tr_rd_fix;
	addr24_t dma_addr_in, dma_addr_out;
	tr_addr_t tr_wr_addr;

	integer seed = 32'h7e61_1e71;
	int errors = 0;
	int timeouts = 0;
	string test_name = "reset";
	logic started = 0, check_wr = 0, copy_mode = 0, busy_rand = 0;
	logic up_check = 0, spr_forbid = 0, fix_check = 0, no_start_check = 0;
	addr24_t exp_wr_addr, exp_src;      // Next expected write and source address
	word_t exp_fill, exp_up_data;
	tr_addr_t exp_up_addr;
	int wr_pulses = 0, spr_pulses = 0, gnt_wait = 0;
	logic wr_prev = 0, spr_prev = 0, gnt_arm = 0;
	logic run_seen = 0;                 // Sticky, catches short runs

	cd_dma_sys i_dut (.*);

	always #2 clk_sys = ~clk_sys;   // 4 ns period

	assign dma_data_in = ~dma_addr_in[15:0];   // Memory model

	// ====================
	// Input models, driven 1 ns after the edge
	always @(posedge clk_sys)
	begin
		#1;
		cpu_clk_en = ~cpu_clk_en;
		sdram_busy = busy_rand ? (($random(seed) & 3) == 0) : 1'b0;
		if (!nbr && nbg && !gnt_arm)
		begin
			gnt_wait = 1 + ($random(seed) & 3);   // Grant a few cycles later
			gnt_arm = 1;
		end
		else if (gnt_arm)
		begin
			gnt_wait = gnt_wait - 1;
			if (gnt_wait == 0)
			begin
				nbg = 0;
				gnt_arm = 0;
			end
		end
		if (!nbgack)
			nbg = 1;   // Grant dropped once acknowledged
	end

	// Write pulse tracking, next expected address per write
	always @(posedge clk_sys)
	begin
		wr_prev <= dma_wr;
		spr_prev <= tr_wr_spr;
		if (dma_running)
			run_seen <= 1;
		if (dma_wr && !wr_prev)
		begin
			wr_pulses <= wr_pulses + 1;
			exp_wr_addr <= exp_wr_addr + 24'd2;
			exp_src <= exp_src + 24'd2;
		end
		if (tr_wr_spr && !spr_prev)
			spr_pulses <= spr_pulses + 1;
	end

	// ====================
	// Checking assertions
	a_reset_idle: assert property (@(posedge clk_sys) disable iff (!nRESET || started)
		nbr && nbgack && !dma_running && !dma_rd && !dma_wr &&
		!(tr_wr_spr | tr_wr_pcm | tr_wr_z80 | tr_wr_fix | tr_rd_spr | tr_rd_z80 | tr_rd_fix))
		else
		begin
			errors++;
			$display("Outputs left their reset levels before the first start");
		end

	a_grant_order: assert property (@(posedge clk_sys) disable iff (!nRESET)
		$fell(nbgack) |-> (!$past(nbr) && !$past(nbg)))
		else
		begin
			errors++;
			$display("nbgack fell without a request and a grant");
		end

	a_release: assert property (@(posedge clk_sys) disable iff (!nRESET)
		$rose(nbgack) == $fell(dma_running))
		else
		begin
			errors++;
			$display("nbgack release and end of dma_running not aligned");
		end

	a_wr_addr: assert property (@(posedge clk_sys) disable iff (!nRESET || !check_wr)
		$rose(dma_wr) |-> (dma_addr_out == exp_wr_addr))
		else
		begin
			errors++;
			$display("ERR %s addr expected %h actual %h", test_name, $sampled(exp_wr_addr),
				$sampled(dma_addr_out));
		end

	a_rd_addr: assert property (@(posedge clk_sys) disable iff (!nRESET || !copy_mode)
		$rose(dma_rd) |-> (dma_addr_in == exp_src))
		else
		begin
			errors++;
			$display("ERR %s read addr expected %h actual %h", test_name, $sampled(exp_src),
				$sampled(dma_addr_in));
		end

	a_wr_data: assert property (@(posedge clk_sys) disable iff (!nRESET || !check_wr)
		$rose(dma_wr) |-> (dma_data_out == (copy_mode ? ~exp_src[15:0] : exp_fill)))
		else
		begin
			errors++;
			$display("ERR %s data expected %h actual %h", test_name,
				copy_mode ? ~$sampled(exp_src[15:0]) : exp_fill, $sampled(dma_data_out));
		end

	a_busy_hold: assert property (@(posedge clk_sys) disable iff (!nRESET)
		(($past(dma_rd) != dma_rd) || ($past(dma_wr) != dma_wr)) |-> !$past(sdram_busy))
		else
		begin
			errors++;
			$display("DMA strobe changed while memory was busy");
		end

	a_up_payload: assert property (@(posedge clk_sys) disable iff (!nRESET || !up_check)
		$fell(tr_wr_spr) |-> (tr_wr_data == exp_up_data && tr_wr_addr == exp_up_addr))
		else
		begin
			errors++;
			$display("ERR %s upload expected %h/%h actual %h/%h", test_name, exp_up_data,
				exp_up_addr, $sampled(tr_wr_data), $sampled(tr_wr_addr));
		end

	a_unmapped: assert property (@(posedge clk_sys) disable iff (!nRESET || !spr_forbid)
		!tr_wr_spr)
		else
		begin
			errors++;
			$display("SPR strobe raised after unmap");
		end

	a_fix_follow: assert property (@(posedge clk_sys) disable iff (!nRESET || !fix_check)
		tr_wr_fix == dma_wr)
		else
		begin
			errors++;
			$display("tr_wr_fix did not follow dma_wr");
		end

	a_no_start: assert property (@(posedge clk_sys) disable iff (!nRESET || !no_start_check)
		nbr)
		else
		begin
			errors++;
			$display("Bus requested after an unknown microcode");
		end

	// ====================
	// Host access and wait tasks
	task automatic host_write(input addr24_t baddr, input word_t data, input logic low_only);
		int i;
		begin
			#1;
			m68k_addr = baddr[23:1];
			m68k_data = data;
			m68k_rw = 0;
			nas = 0;
			@(posedge clk_sys);
			#1;
			nlds = 0;
			nuds = low_only;
			for (i = 0; i < 16; i++)
			begin
				@(posedge clk_sys);
				if (cpu_clk_en)
					break;   // Strobe edge sampled here
			end
			if (i == 16)
			begin
				timeouts++;
				$display("Timed out waiting for a CPU clock enable");
			end
			repeat (2) @(posedge clk_sys);
			#1;
			nlds = 1;
			nuds = 1;
			nas = 1;
			m68k_rw = 1;
			m68k_addr = '0;
			repeat (4) @(posedge clk_sys);
		end
	endtask

	// Start seen through the sticky flag, end seen on the live level
	task automatic wait_running(input logic level, input int limit);
		int i;
		begin
			for (i = 0; i < limit; i++)
			begin
				@(posedge clk_sys);
				#1;
				if (level ? run_seen : !dma_running)
					break;
			end
			if (i == limit)
			begin
				timeouts++;
				$display("Timed out in %s waiting for dma_running to become %0b",
					test_name, level);
			end
		end
	endtask

	task automatic setup_dma(input addr24_t a, input addr24_t b, input word_t v,
		input count_t n, input word_t ucode);
		begin
			host_write({`CD_REG_WINDOW, `REG_DMA_ADDR_A_HI}, {8'h00, a[23:16]}, 0);
			host_write({`CD_REG_WINDOW, `REG_DMA_ADDR_A_LO}, a[15:0], 0);
			host_write({`CD_REG_WINDOW, `REG_DMA_ADDR_B_HI}, {8'h00, b[23:16]}, 0);
			host_write({`CD_REG_WINDOW, `REG_DMA_ADDR_B_LO}, b[15:0], 0);
			host_write({`CD_REG_WINDOW, `REG_DMA_VALUE}, v, 0);
			host_write({`CD_REG_WINDOW, `REG_DMA_COUNT_HI}, {8'h00, n[23:16]}, 0);
			host_write({`CD_REG_WINDOW, `REG_DMA_COUNT_LO}, n[15:0], 0);
			host_write({`CD_REG_WINDOW, `REG_DMA_UCODE0}, ucode, 0);
			wr_pulses = 0;
			run_seen = 0;
			exp_fill = v;
			exp_src = a;
			exp_wr_addr = copy_mode ? b : a;
			started = 1;
			host_write({`CD_REG_WINDOW, `REG_DMA_START}, 16'h0040, 1);
		end
	endtask

	task automatic run_and_count(input int n);
		begin
			wait_running(1, 200);
			wait_running(0, 4000);
			if (wr_pulses != n)
			begin
				errors++;
				$display("ERR %s writes expected %0d actual %0d", test_name, n, wr_pulses);
			end
		end
	endtask

	// ====================
	// Stimulus
	initial
	begin
		nRESET = 0;
		{cpu_clk_en, m68k_rw, nas, nlds, nuds, ndtack, nbg, sys_is_cd} = 8'b0111_1111;
		sdram_busy = 0;
		m68k_addr = '0;
		m68k_data = '0;
		repeat (10) @(posedge clk_sys);
		#1;
		nRESET = 1;
		repeat (20) @(posedge clk_sys);

		test_name = "fill";
		check_wr = 1;
		setup_dma(24'h012340, 24'h000000, 16'hBEEF, 24'd4, `UCODE_WORD_FILL);
		run_and_count(4);

		test_name = "copy";
		copy_mode = 1;
		busy_rand = 1;
		setup_dma(24'h020000, 24'h030010, 16'h0000, 24'd5, `UCODE_WORD_COPY);
		run_and_count(5);
		busy_rand = 0;
		copy_mode = 0;

		test_name = "upload";
		host_write({`CD_REG_WINDOW, `REG_TR_AREA}, 16'(`AREA_SPR), 1);
		host_write({`CD_REG_WINDOW, `REG_MAP_SPR}, 16'h0001, 1);
		exp_up_data = 16'hA55A;
		exp_up_addr = 19'h0091A;   // Word address bits of E01234
		up_check = 1;
		host_write(24'hE01234, 16'hA55A, 0);
		up_check = 0;
		if (spr_pulses != 1)
		begin
			errors++;
			$display("ERR %s spr pulses expected 1 actual %0d", test_name, spr_pulses);
		end
		host_write({`CD_REG_WINDOW, `REG_UNMAP_SPR}, 16'h0001, 1);
		spr_forbid = 1;
		host_write(24'hE01234, 16'hA55A, 0);
		spr_forbid = 0;

		test_name = "fix fill";
		host_write({`CD_REG_WINDOW, `REG_TR_AREA}, 16'(`AREA_FIX), 1);
		host_write({`CD_REG_WINDOW, `REG_MAP_FIX}, 16'h0001, 1);
		fix_check = 1;
		setup_dma(24'hE00100, 24'h000000, 16'h1234, 24'd2, `UCODE_WORD_FILL);
		run_and_count(2);
		fix_check = 0;

		test_name = "bad ucode";
		no_start_check = 1;
		setup_dma(24'h001000, 24'h002000, 16'h0000, 24'd3, 16'h1111);
		repeat (200) @(posedge clk_sys);
		no_start_check = 0;

		test_name = "count zero";
		setup_dma(24'h004000, 24'h000000, 16'h5555, 24'd0, `UCODE_WORD_FILL);
		run_and_count(0);

		repeat (10) @(posedge clk_sys);
		$display("Checks done, %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// Overall run limit
	initial
	begin
		#400000;
		$display("Simulation ran past its time limit");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: cd_dma_sys.f
+incdir+include
logic/cd_dma_pkg.sv
logic/host_bus_decode.sv
logic/cd_ctrl_regs.sv
logic/dma_sequencer.sv
logic/upload_router.sv
logic/cd_dma_sys.sv
dv/tb_cd_dma_sys.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CD DMA testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f cd_dma_sys.f \
	--top-module tb_cd_dma_sys -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
	echo "Simulation reported failure, see sim.log"
	exit 1
fi
echo "Simulation finished without failure"
exit 0
